/* Bender.yml */
package:
  name: spmv_row_engine

sources:
  - files:
      - logic/spmv_pkg.sv
      - logic/delay_line.sv
      - logic/row_decode.sv
      - logic/product_stage.sv
      - logic/segment_reduce.sv
      - logic/spmv_row_engine.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_spmv.sv

/* logic/delay_line.sv */
`timescale 1ns/1ps

module delay_line #(
    parameter type payload_t = logic,
    parameter int  depth     = 1
) (
    input  logic     clock,
    input  logic     reset_n,
    input  payload_t in,
    output payload_t out
);

    payload_t stages [depth];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in;
            // older entries move one stage down per cycle
            for (int i = 1; i < depth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out = stages[depth-1];

endmodule

/* logic/product_stage.sv */
`timescale 1ns/1ps

module product_stage (
    input  logic                                      clock,
    input  spmv_pkg::chunk_t                          chunk,
    input  spmv_pkg::vector_t                         vector,
    output spmv_pkg::data_t [spmv_pkg::lane_count-1:0] products
);

    import spmv_pkg::*;

    data_t [lane_count-1:0] selected;

    // each lane picks the vector entry named by its column index
    always_comb begin
        for (int i = 0; i < lane_count; i++) begin
            selected[i] = vector[chunk.column[i]];
        end
    end

    // product keeps only the low data_width bits
    always_ff @(posedge clock) begin
        for (int i = 0; i < lane_count; i++) begin
            products[i] <= data_t'(chunk.value[i] * selected[i]);
        end
    end

endmodule

/* logic/row_decode.sv */
`timescale 1ns/1ps

module row_decode (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     start,
    input  spmv_pkg::row_end_table_t row_ends,
    output logic                     busy,
    output logic                     chunk_fire,
    output spmv_pkg::lane_tag_t      tag
);

    import spmv_pkg::*;

    row_end_table_t            table_q;
    row_end_table_t            active_table;
    logic                      busy_q;
    logic [lane_idx_width-1:0] chunk_q;
    logic [lane_idx_width-1:0] chunk_idx;
    logic [lane_idx_width-1:0] last_chunk;
    logic [lane_idx_width-1:0] done_q;
    logic [lane_idx_width-1:0] done_base;
    logic [lane_idx_width-1:0] rows_done;
    logic                      more_chunks;

    // the start cycle already carries chunk 0, so use the table straight from the port
    assign active_table = start ? row_ends : table_q;
    assign chunk_idx    = start ? '0 : chunk_q;
    assign done_base    = start ? '0 : done_q;

    // upper half of the final row end is the index of the last chunk
    assign last_chunk  = active_table[lane_count-1][flat_idx_width-1 -: lane_idx_width];
    assign more_chunks = chunk_idx != last_chunk;

    assign busy       = start | busy_q;
    assign chunk_fire = busy;

    always_comb begin
        logic [lane_idx_width-1:0] order;
        logic [lane_idx_width-1:0] slot;
        order = '0;
        slot  = '0;
        tag   = '0;
        // lane i ends a row when some row end lands on this chunk at lane i
        for (int i = 0; i < lane_count; i++) begin
            for (int r = 0; r < lane_count; r++) begin
                if (chunk_fire &&
                    active_table[r] == {chunk_idx, lane_idx_width'(i)}) begin
                    tag.row_end[i] = 1'b1;
                end
            end
        end
        // finished rows take consecutive output slots after the rows already done
        for (int k = 0; k < lane_count; k++) begin
            if (tag.row_end[k]) begin
                slot = done_base + order;
                tag.slot_lane[slot]  = lane_idx_width'(k);
                tag.slot_valid[slot] = 1'b1;
                order = order + 1'b1;
            end
        end
        rows_done = order;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            table_q <= '0;
            busy_q  <= 1'b0;
            chunk_q <= '0;
            done_q  <= '0;
        end else begin
            if (start) begin
                table_q <= row_ends;
            end
            busy_q  <= chunk_fire && more_chunks;
            chunk_q <= (chunk_fire && more_chunks) ? chunk_idx + 1'b1 : '0;
            // wraps to zero once all rows are done
            done_q  <= chunk_fire ? done_base + rows_done : '0;
        end
    end

    // a new matrix may only start once the previous one has left decode
    assert property (@(posedge clock) disable iff (!reset_n) start |-> !busy_q)
        else $error("start while busy");

endmodule

/* logic/segment_reduce.sv */
`timescale 1ns/1ps

module segment_reduce (
    input  logic                                      clock,
    input  logic                                      reset_n,
    input  spmv_pkg::data_t [spmv_pkg::lane_count-1:0] products,
    input  spmv_pkg::lane_tag_t                       tag,
    output spmv_pkg::row_result_t                     result
);

    import spmv_pkg::*;

    data_t [lane_count-1:0]                    scan [lane_idx_width+1];
    data_t [lane_count-1:0]                    seg_next;
    data_t [lane_count-1:0]                    seg_sum;
    lane_tag_t                                 tag_d;
    logic [lane_count-1:0][lane_idx_width-1:0] slot_lane_q;
    logic [lane_count-1:0]                     slot_valid_q;

    assign scan[0] = products;

    // Hillis-Steele inclusive prefix sum, one register per stage
    for (genvar s = 0; s < lane_idx_width; s++) begin : g_scan
        localparam int step = 1 << s;
        always_ff @(posedge clock) begin
            for (int j = 0; j < lane_count; j++) begin
                if (j >= step) begin
                    scan[s+1][j] <= scan[s][j] + scan[s][j-step];
                end else begin
                    scan[s+1][j] <= scan[s][j];
                end
            end
        end
    end

    // tags wait for the scan to finish
    delay_line #(
        .payload_t (lane_tag_t),
        .depth     (lane_idx_width)
    ) u_tag_delay (
        .clock   (clock),
        .reset_n (reset_n),
        .in      (tag),
        .out     (tag_d)
    );

    // segment sum is the prefix at this row end minus the prefix at the previous one
    always_comb begin
        data_t base;
        base = '0;
        for (int i = 0; i < lane_count; i++) begin
            seg_next[i] = '0;
            if (tag_d.row_end[i]) begin
                seg_next[i] = scan[lane_idx_width][i] - base;
                base = scan[lane_idx_width][i];
            end
        end
    end

    always_ff @(posedge clock) begin
        seg_sum <= seg_next;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            slot_lane_q  <= '0;
            slot_valid_q <= '0;
        end else begin
            slot_lane_q  <= tag_d.slot_lane;
            slot_valid_q <= tag_d.slot_valid;
        end
    end

    // gather each finished row's sum into its slot, empty slots read zero
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            result <= '0;
        end else begin
            for (int s = 0; s < lane_count; s++) begin
                result.valid[s] <= slot_valid_q[s];
                result.sum[s]   <= slot_valid_q[s] ? seg_sum[slot_lane_q[s]] : '0;
            end
        end
    end

    // slots built in decode must point at lanes that really end a row
    for (genvar s = 0; s < lane_count; s++) begin : g_slot_check
        assert property (@(posedge clock) disable iff (!reset_n)
            tag_d.slot_valid[s] |-> tag_d.row_end[tag_d.slot_lane[s]])
            else $error("slot %0d points at a lane without a row end", s);
    end

endmodule

/* logic/spmv_pkg.sv */
package spmv_pkg;

    // lanes per chunk, also the number of matrix rows
    localparam int lane_count = 16;

    // values, vector entries, products and sums all share this width
    localparam int data_width = 8;

    localparam int lane_idx_width = $clog2(lane_count);

    // flat nonzero position = chunk index and lane index concatenated
    localparam int flat_idx_width = 2 * lane_idx_width;

    // scan stages plus segment register plus gather register
    localparam int result_latency = lane_idx_width + 2;

    typedef logic [data_width-1:0] data_t;

    // entry r holds the flat position of the last nonzero of row r
    typedef logic [lane_count-1:0][flat_idx_width-1:0] row_end_table_t;

    typedef struct packed {
        data_t [lane_count-1:0]                     value;
        logic  [lane_count-1:0][lane_idx_width-1:0] column;
    } chunk_t;

    typedef data_t [lane_count-1:0] vector_t;

    // row_end is per lane, slot_lane and slot_valid are per output row
    typedef struct packed {
        logic [lane_count-1:0]                     row_end;
        logic [lane_count-1:0][lane_idx_width-1:0] slot_lane;
        logic [lane_count-1:0]                     slot_valid;
    } lane_tag_t;

    typedef struct packed {
        data_t [lane_count-1:0] sum;
        logic  [lane_count-1:0] valid;
    } row_result_t;

endpackage

/* logic/spmv_row_engine.sv */
`timescale 1ns/1ps

module spmv_row_engine (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     start,
    input  spmv_pkg::row_end_table_t row_ends,
    input  spmv_pkg::chunk_t         chunk,
    input  spmv_pkg::vector_t        vector,
    output logic                     busy,
    output spmv_pkg::row_result_t    result
);

    import spmv_pkg::*;

    lane_tag_t              tag;
    lane_tag_t              tag_aligned;
    data_t [lane_count-1:0] products;

    row_decode u_row_decode (
        .clock      (clock),
        .reset_n    (reset_n),
        .start      (start),
        .row_ends   (row_ends),
        .busy       (busy),
        .chunk_fire (),
        .tag        (tag)
    );

    product_stage u_product_stage (
        .clock    (clock),
        .chunk    (chunk),
        .vector   (vector),
        .products (products)
    );

    // one stage to line the tags up with the registered products
    delay_line #(
        .payload_t (lane_tag_t),
        .depth     (1)
    ) u_tag_align (
        .clock   (clock),
        .reset_n (reset_n),
        .in      (tag),
        .out     (tag_aligned)
    );

    segment_reduce u_segment_reduce (
        .clock    (clock),
        .reset_n  (reset_n),
        .products (products),
        .tag      (tag_aligned),
        .result   (result)
    );

endmodule

/* tb.f */
+incdir+testbench
logic/spmv_pkg.sv
logic/delay_line.sv
logic/row_decode.sv
logic/product_stage.sv
logic/segment_reduce.sv
logic/spmv_row_engine.sv
testbench/tb_spmv.sv

/* testbench/spmv_model.svh */
`ifndef SPMV_MODEL_SVH
`define SPMV_MODEL_SVH

// number of chunks follows from the final row end
function automatic int chunk_count(row_end_table_t t);
    return int'(t[lane_count-1]) / lane_count + 1;
endfunction

// rows whose last nonzero falls in chunk c
function automatic logic [lane_count-1:0] row_mask(row_end_table_t t, int c);
    logic [lane_count-1:0] mask;
    mask = '0;
    for (int r = 0; r < lane_count; r++) begin
        mask[r] = (int'(t[r]) / lane_count) == c;
    end
    return mask;
endfunction

// row r times the dense vector, wrapping at data_width bits
// a row starts one past the previous row end and never leaves its chunk
function automatic data_t row_sum(row_end_table_t t, int r, chunk_t ch, vector_t v);
    int    first;
    int    lane;
    data_t acc;
    first = (r == 0) ? 0 : int'(t[r-1]) + 1;
    acc   = '0;
    for (int p = first; p <= int'(t[r]); p++) begin
        lane = p % lane_count;
        acc  = acc + data_t'(ch.value[lane] * v[ch.column[lane]]);
    end
    return acc;
endfunction

`endif

/* testbench/tb_spmv.sv */
`timescale 1ns/1ps

module tb_spmv;

    import spmv_pkg::*;

    `include "spmv_model.svh"

    localparam int clock_period = 4;
    localparam int num_random   = 40;
    localparam int max_gap      = 3;
    // reset, lead-in, directed matrix, random matrices with gaps, drain, margin
    localparam int watchdog_cycles = 4 + 6 + 2 + num_random * (lane_count + max_gap)
                                     + result_latency + 2 + 50;

    typedef struct packed {
        int          due;
        row_result_t value;
    } pending_t;

    logic           clock = 1'b0;
    logic           reset_n;
    logic           start;
    row_end_table_t row_ends;
    chunk_t         chunk;
    vector_t        vector;
    logic           busy;
    row_result_t    result;

    int       seed  = 39;
    int       cycle = 0;
    bit       busy_expect [int];
    pending_t pending [$];

    spmv_row_engine u_spmv_row_engine (
        .clock    (clock),
        .reset_n  (reset_n),
        .start    (start),
        .row_ends (row_ends),
        .chunk    (chunk),
        .vector   (vector),
        .busy     (busy),
        .result   (result)
    );

    always #(clock_period / 2) clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_busy(input logic got, input logic want);
        if (got !== want) begin
            stop_on_failure($sformatf("[ERROR] %0d ns: busy is %b, expected %b",
                                      $time, got, want));
        end
    endtask

    task automatic compare_result(input row_result_t got, input row_result_t want);
        if (got !== want) begin
            stop_on_failure($sformatf(
                "[ERROR] %0d ns: result valid %h sums %h, expected valid %h sums %h",
                $time, got.valid, got.sum, want.valid, want.sum));
        end
    endtask

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic chunk_t random_chunk();
        chunk_t ch;
        for (int i = 0; i < lane_count; i++) begin
            ch.value[i]  = data_t'($random(seed));
            ch.column[i] = lane_idx_width'(rand_below(lane_count));
        end
        return ch;
    endfunction

    function automatic vector_t random_vector();
        vector_t v;
        for (int i = 0; i < lane_count; i++) begin
            v[i] = data_t'($random(seed));
        end
        return v;
    endfunction

    // strictly rising row ends, every chunk but the last closes on lane 15
    function automatic row_end_table_t random_table();
        int             n_chunks;
        int             per_chunk [lane_count];
        bit             used [lane_count];
        int             extra;
        int             c;
        int             picked;
        int             r;
        row_end_table_t t;
        n_chunks = 1 + rand_below(lane_count);
        for (int i = 0; i < lane_count; i++) begin
            per_chunk[i] = (i < n_chunks) ? 1 : 0;
        end
        extra = lane_count - n_chunks;
        while (extra > 0) begin
            c = rand_below(n_chunks);
            if (per_chunk[c] < lane_count) begin
                per_chunk[c]++;
                extra--;
            end
        end
        r = 0;
        for (c = 0; c < n_chunks; c++) begin
            for (int i = 0; i < lane_count; i++) begin
                used[i] = (c < n_chunks - 1) && (i == lane_count - 1);
            end
            picked = (c < n_chunks - 1) ? 1 : 0;
            while (picked < per_chunk[c]) begin
                extra = rand_below(lane_count);
                if (!used[extra]) begin
                    used[extra] = 1'b1;
                    picked++;
                end
            end
            for (int i = 0; i < lane_count; i++) begin
                if (used[i]) begin
                    t[r] = flat_idx_width'(c * lane_count + i);
                    r++;
                end
            end
        end
        return t;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
            start = 1'b0;
            chunk = random_chunk();
        end
    endtask

    // streams one matrix a chunk per cycle and queues the expected results
    task automatic run_matrix(input row_end_table_t t, input vector_t v);
        chunk_t   ch;
        pending_t entry;
        for (int c = 0; c < chunk_count(t); c++) begin
            @(posedge clock);
            #1;
            ch    = random_chunk();
            start = (c == 0);
            chunk = ch;
            if (c == 0) begin
                row_ends = t;
                vector   = v;
            end
            busy_expect[cycle] = 1'b1;
            entry.due         = cycle + 1 + result_latency;
            entry.value.valid = row_mask(t, c);
            for (int r = 0; r < lane_count; r++) begin
                entry.value.sum[r] = entry.value.valid[r] ? row_sum(t, r, ch, v) : '0;
            end
            pending.push_back(entry);
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clock) begin : check_outputs
        row_result_t want;
        pending_t    head;
        want = '0;
        if (pending.size() > 0 && pending[0].due == cycle) begin
            head = pending.pop_front();
            want = head.value;
        end
        compare_busy(busy, busy_expect.exists(cycle));
        compare_result(result, want);
    end

    initial begin : watchdog
        #(watchdog_cycles * clock_period);
        stop_on_failure($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
    end

    initial begin : stimulus
        row_end_table_t ident;
        reset_n  = 1'b0;
        start    = 1'b0;
        row_ends = '0;
        chunk    = '0;
        vector   = '0;
        repeat (4) @(posedge clock);
        #1;
        reset_n = 1'b1;
        idle_cycles(6);

        // one nonzero per row, all in a single chunk
        for (int r = 0; r < lane_count; r++) begin
            ident[r] = flat_idx_width'(r);
        end
        run_matrix(ident, random_vector());
        idle_cycles(2);

        for (int i = 0; i < num_random; i++) begin
            run_matrix(random_table(), random_vector());
            // every fourth matrix follows immediately
            idle_cycles((i % 4 == 0) ? 0 : rand_below(max_gap + 1));
        end
        idle_cycles(result_latency + 2);

        if (pending.size() != 0) begin
            stop_on_failure("some expected results never appeared on the output");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule
